/* armExe.f */
+incdir+verilog
verilog/aluTypesPkg.sv
verilog/exeIfPkg.sv
verilog/aluDecoder.sv
verilog/aluDatapath.sv
verilog/exeStage.sv
verilog/armExe.sv
sim/armExeTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the armExe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  -f armExe.f \
  --top-module armExeTb \
  -o armExeSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/armExeSim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished cleanly"
exit 0

/* sim/armExeTb.sv */
`timescale 1ns/1ps
`default_nettype none

module armExeTb;
  import aluTypesPkg::*;
  import exeIfPkg::*;

  localparam int TBL_LEN = 19;
  localparam int RAND_CNT = 400;

  typedef struct packed {
    opcode_t opc;
    logic    s;
    word_t   a;
    word_t   b;
    logic    sh;
    word_t   res;      // Expected result
    logic    wr;       // Expected wrEn
    flags_t  fl;       // Expected NZCV after the op
  } tblEntry_t;

  logic        clk;
  logic        rst;
  exeReq_t     req;
  logic        inVld;
  logic        inRdy;
  exeResp_t    resp;
  logic        outVld;
  logic        outRdy;
  logic        randReady;            // Random stalls enabled
  logic [31:0] seed;                 // Traffic LCG state
  logic [31:0] rdySeed;              // outRdy LCG state
  logic        prevStall;
  exeResp_t    prevResp;
  flags_t      modelFlags;
  tblEntry_t   tbl [TBL_LEN];
  exeResp_t    expQ[$];              // Responses still owed by the DUT

  armExe armExe_i (
    .clk(clk), .rst(rst), .req(req), .inVld(inVld), .inRdy(inRdy),
    .resp(resp), .outVld(outVld), .outRdy(outRdy)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // Reference behavior straight from the ARM data-processing rules
  task automatic modelOp(input exeReq_t r, input flags_t fIn, output word_t res,
                         output flags_t fOut);
    word_t x;
    word_t y;
    logic  cb;          // Carry-in for adds, borrow for subtracts
    int    kind;        // 0 logic, 1 add, 2 sub
    logic [32:0] wide;
    x = r.a;
    y = r.b;
    cb = 1'b0;
    kind = 0;
    res = '0;
    case (r.opcode)
      OPC_AND, OPC_TST: res = r.a & r.b;
      OPC_EOR, OPC_TEQ: res = r.a ^ r.b;
      OPC_ORR:          res = r.a | r.b;
      OPC_MOV:          res = r.b;
      OPC_BIC:          res = r.a & ~r.b;
      OPC_MVN:          res = ~r.b;
      OPC_ADD, OPC_CMN: kind = 1;
      OPC_ADC: begin
        kind = 1;
        cb = fIn.c;
      end
      OPC_SUB, OPC_CMP: kind = 2;
      OPC_RSB: begin
        kind = 2;
        x = r.b;
        y = r.a;
      end
      OPC_SBC: begin
        kind = 2;
        cb = ~fIn.c;
      end
      default: begin    // RSC
        kind = 2;
        x = r.b;
        y = r.a;
        cb = ~fIn.c;
      end
    endcase
    fOut = '{n: 1'b0, z: 1'b0, c: r.shCarry, v: fIn.v};
    if (kind == 1) begin
      wide = {1'b0, x} + {1'b0, y} + {32'b0, cb};
      res = wide[31:0];
      fOut.c = wide[32];
      fOut.v = (x[31] == y[31]) && (res[31] != x[31]);
    end else if (kind == 2) begin
      res = x - y - {31'b0, cb};
      fOut.c = ({1'b0, x} >= ({1'b0, y} + {32'b0, cb}));  // No borrow
      fOut.v = (x[31] != y[31]) && (res[31] != x[31]);
    end
    fOut.n = res[31];
    fOut.z = (res == '0);
  endtask

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic sendReq(input exeReq_t r, input exeResp_t e);
    req = r;
    inVld = 1'b1;
    #1;
    while (!inRdy) begin
      @(negedge clk);
      #1;
    end
    expQ.push_back(e);
    @(negedge clk);
    inVld = 1'b0;
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      rdySeed = lcg(rdySeed);
      outRdy = randReady ? rdySeed[30] | rdySeed[27] : 1'b1;  // About 75 % ready
    end
  end

  // Response monitor, registered outputs read at the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (prevStall) begin
        check("outVld held under stall", {31'b0, outVld}, 32'd1);
        check("resp held under stall", {31'b0, resp == prevResp}, 32'd1);
      end
      if (outVld && outRdy) begin
        if (expQ.size() == 0) begin
          $display("Response arrived with no request outstanding");
          $display(">>> FAIL");
          $fatal(1, "extra response");
        end else begin
          check("result", resp.result, expQ[0].result);
          check("rd", {28'b0, resp.rd}, {28'b0, expQ[0].rd});
          check("wrEn", {31'b0, resp.wrEn}, {31'b0, expQ[0].wrEn});
          check("flags", {28'b0, resp.flags}, {28'b0, expQ[0].flags});
          void'(expQ.pop_front());
        end
      end
      prevStall = outVld && !outRdy;
      prevResp = resp;
    end
  end

  initial begin
    #((TBL_LEN + RAND_CNT) * 20 * 10 + 200);
    $display("Watchdog expired before all responses arrived");
    $display(">>> FAIL");
    $fatal(1, "simulation timed out");
  end

  initial begin
    exeReq_t  r;
    exeResp_t e;
    flags_t   f;
    word_t    res;
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    inVld = 1'b0;
    outRdy = 1'b1;
    randReady = 1'b0;
    seed = 32'h3f3a;
    rdySeed = lcg(32'h3f3a);
    prevStall = 1'b0;
    prevResp = '0;
    // Fields opcode S a b shCarry result wrEn NZCV
    // Entries go out back to back
    tbl[0]  = '{OPC_MOV, 1'b0, 32'h0, 32'h12, 1'b1, 32'h12, 1'b1, 4'b0000};  // Reset flags
    tbl[1]  = '{OPC_ADD, 1'b1, 32'h7fffffff, 32'h1, 1'b0, 32'h80000000, 1'b1, 4'b1001};
    tbl[2]  = '{OPC_SUB, 1'b1, 32'h5, 32'h5, 1'b0, 32'h0, 1'b1, 4'b0110};
    tbl[3]  = '{OPC_ADC, 1'b1, 32'd10, 32'd20, 1'b0, 32'd31, 1'b1, 4'b0000};
    tbl[4]  = '{OPC_SBC, 1'b1, 32'd10, 32'd3, 1'b0, 32'd6, 1'b1, 4'b0010};
    tbl[5]  = '{OPC_RSC, 1'b0, 32'd3, 32'd10, 1'b0, 32'd7, 1'b1, 4'b0010};
    tbl[6]  = '{OPC_RSB, 1'b1, 32'd10, 32'd3, 1'b0, 32'hfffffff9, 1'b1, 4'b1000};
    tbl[7]  = '{OPC_ADD, 1'b1, 32'h7fffffff, 32'h1, 1'b0, 32'h80000000, 1'b1, 4'b1001};
    tbl[8]  = '{OPC_EOR, 1'b1, 32'hff, 32'h0f, 1'b1, 32'hf0, 1'b1, 4'b0011};   // V kept
    tbl[9]  = '{OPC_ORR, 1'b1, 32'hf00, 32'h0f, 1'b0, 32'hf0f, 1'b1, 4'b0001};
    tbl[10] = '{OPC_BIC, 1'b0, 32'hff, 32'h0f, 1'b1, 32'hf0, 1'b1, 4'b0001};
    tbl[11] = '{OPC_MVN, 1'b1, 32'h0, 32'h0, 1'b0, 32'hffffffff, 1'b1, 4'b1001};
    tbl[12] = '{OPC_TST, 1'b1, 32'hf0, 32'h0f, 1'b1, 32'h0, 1'b0, 4'b0111};
    tbl[13] = '{OPC_TEQ, 1'b1, 32'h5, 32'h5, 1'b0, 32'h0, 1'b0, 4'b0101};
    tbl[14] = '{OPC_CMP, 1'b1, 32'h3, 32'h5, 1'b0, 32'hfffffffe, 1'b0, 4'b1000};
    tbl[15] = '{OPC_CMN, 1'b1, 32'hffffffff, 32'h1, 1'b0, 32'h0, 1'b0, 4'b0110};
    tbl[16] = '{OPC_CMP, 1'b0, 32'h1, 32'h1, 1'b1, 32'h0, 1'b0, 4'b0110};
    tbl[17] = '{OPC_ADC, 1'b1, 32'h1, 32'h1, 1'b0, 32'h3, 1'b1, 4'b0000};
    tbl[18] = '{OPC_AND, 1'b1, 32'hf0f0, 32'hff00, 1'b1, 32'hf000, 1'b1, 4'b0010};
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("outVld after reset", {31'b0, outVld}, 32'd0);
    check("inRdy after reset", {31'b0, inRdy}, 32'd1);
    for (int i = 0; i < TBL_LEN; i++) begin
      r = '{opcode: tbl[i].opc, setFlags: tbl[i].s, rd: i[3:0], a: tbl[i].a,
            b: tbl[i].b, shCarry: tbl[i].sh};
      e = '{result: tbl[i].res, rd: i[3:0], wrEn: tbl[i].wr, flags: tbl[i].fl};
      sendReq(r, e);
    end
    modelFlags = tbl[TBL_LEN-1].fl;
    randReady = 1'b1;
    for (int i = 0; i < RAND_CNT; i++) begin
      seed = lcg(seed);
      while (seed[29:28] == 2'b00) begin   // Idle gaps on inVld
        @(negedge clk);
        seed = lcg(seed);
      end
      r.opcode = opcode_t'(seed[19:16]);
      r.setFlags = seed[26];
      r.rd = seed[25:22];
      r.shCarry = seed[21];
      seed = lcg(seed);
      r.a = seed[31] ? {seed[30], 31'h7fffffff ^ {16'b0, seed[15:1]}} : seed;
      seed = lcg(seed);
      r.b = seed[31] ? seed[31:16] : {seed[15:0], seed[31:16]};
      modelOp(r, modelFlags, res, f);
      if (r.setFlags) begin
        modelFlags = f;
      end
      e.result = res;
      e.rd = r.rd;
      e.wrEn = !(r.opcode inside {OPC_TST, OPC_TEQ, OPC_CMP, OPC_CMN});
      e.flags = modelFlags;
      sendReq(r, e);
    end
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/aluDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "armExe_settings.svh"

module aluDatapath (
  input  aluTypesPkg::aluCtrl_t ctrl,
  input  aluTypesPkg::word_t    a,
  input  aluTypesPkg::word_t    b,
  input  logic                  shCarry,   // From barrel shifter
  input  exeIfPkg::flags_t      flagsIn,   // Current NZCV
  output aluTypesPkg::word_t    result,
  output exeIfPkg::flags_t      flagsOut   // NZCV if flags were set
);
  import aluTypesPkg::*;

  localparam int MSB = `EXE_DATA_W - 1;

  word_t                opA;       // First operand after swap
  word_t                opBRaw;    // Second operand after swap
  word_t                opB;       // Second operand after inversion
  logic [`EXE_DATA_W:0] sum;       // Carry-out in top bit
  logic                 carry;
  logic                 overflow;
  logic                 signsDiffer;
  logic                 sumSignFlip;

  assign opA    = ctrl.reverseInputs ? b : a;
  assign opBRaw = ctrl.reverseInputs ? a : b;
  assign opB    = ctrl.invertB ? ~opBRaw : opBRaw;

  // One adder for every add, subtract and compare
  assign sum = {1'b0, opA} + {1'b0, opB} + {{`EXE_DATA_W{1'b0}}, ctrl.carryIn};

  always_comb begin
    case (ctrl.op)
      OP_AND:  result = opA & opB;
      OP_XOR:  result = opA ^ opB;
      OP_OR:   result = opA | opB;
      OP_PASS: result = opB;           // MOV, MVN
      default: result = sum[MSB:0];
    endcase
  end

  // Overflow terms use the un-inverted second operand
  assign signsDiffer = opA[MSB] ^ opBRaw[MSB];
  assign sumSignFlip = opA[MSB] ^ sum[MSB];

  always_comb begin
    case (ctrl.cvRule)
      CV_ADD: begin
        carry    = sum[`EXE_DATA_W];
        overflow = ~signsDiffer & sumSignFlip;   // Like signs, sign changed
      end
      CV_SUB: begin
        carry    = sum[`EXE_DATA_W];              // High means no borrow
        overflow = signsDiffer & sumSignFlip;
      end
      default: begin
        carry    = shCarry;
        overflow = flagsIn.v;                     // V untouched by logic ops
      end
    endcase
  end

  assign flagsOut = '{
    n: result[MSB],
    z: (result == '0),
    c: carry,
    v: overflow
  };

endmodule

`default_nettype wire

/* verilog/aluDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
  input  aluTypesPkg::opcode_t  opcode,     // Instr bits 24..21
  input  logic                  carryFlag,  // Current C flag
  output aluTypesPkg::aluCtrl_t ctrl
);
  import aluTypesPkg::*;

  aluOp_t  op;
  cvRule_t cvRule;
  logic    invertB;
  logic    reverseInputs;
  logic    carryIn;
  logic    noWrite;

  // Reverse subtracts swap the operands
  assign reverseInputs = opcode inside {OPC_RSB, OPC_RSC};

  // Subtracts use A + ~B + 1, BIC and MVN need ~B too
  assign invertB = opcode inside {OPC_SUB, OPC_RSB, OPC_SBC, OPC_RSC,
                                  OPC_CMP, OPC_MVN, OPC_BIC};

  assign noWrite = opcode inside {OPC_TST, OPC_TEQ, OPC_CMP, OPC_CMN};

  always_comb begin
    case (opcode)
      OPC_SUB, OPC_RSB, OPC_CMP: carryIn = 1'b1;       // Two's complement +1
      OPC_ADC, OPC_SBC, OPC_RSC: carryIn = carryFlag;  // Chained ops
      default:                   carryIn = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      OPC_AND, OPC_TST, OPC_BIC: op = OP_AND;   // BIC via inverted B
      OPC_EOR, OPC_TEQ:          op = OP_XOR;
      OPC_ORR:                   op = OP_OR;
      OPC_MOV, OPC_MVN:          op = OP_PASS;  // MVN via inverted B
      default:                   op = OP_SUM;   // All arithmetic and compares
    endcase
  end

  always_comb begin
    case (opcode)
      OPC_ADD, OPC_ADC, OPC_CMN: cvRule = CV_ADD;
      OPC_SUB, OPC_RSB, OPC_SBC,
      OPC_RSC, OPC_CMP:          cvRule = CV_SUB;
      default:                   cvRule = CV_LOGIC;  // Logical ops and moves
    endcase
  end

  assign ctrl = '{
    op:            op,
    invertB:       invertB,
    reverseInputs: reverseInputs,
    carryIn:       carryIn,
    cvRule:        cvRule,
    noWrite:       noWrite
  };

endmodule

`default_nettype wire

/* verilog/aluTypesPkg.sv */
`default_nettype none

`include "armExe_settings.svh"

package aluTypesPkg;

  typedef logic [`EXE_DATA_W-1:0] word_t;  // One data word

  // ARM data-processing opcodes, encodings 0..15
  typedef enum logic [`EXE_OPC_W-1:0] {
    OPC_AND = 4'd0,
    OPC_EOR = 4'd1,
    OPC_SUB = 4'd2,
    OPC_RSB = 4'd3,
    OPC_ADD = 4'd4,
    OPC_ADC = 4'd5,
    OPC_SBC = 4'd6,
    OPC_RSC = 4'd7,
    OPC_TST = 4'd8,
    OPC_TEQ = 4'd9,
    OPC_CMP = 4'd10,
    OPC_CMN = 4'd11,
    OPC_ORR = 4'd12,
    OPC_MOV = 4'd13,
    OPC_BIC = 4'd14,
    OPC_MVN = 4'd15
  } opcode_t;

  // Result mux classes
  typedef enum logic [`EXE_ALUOP_W-1:0] {
    OP_AND  = 3'b000,
    OP_XOR  = 3'b001,
    OP_SUM  = 3'b010,
    OP_OR   = 3'b011,
    OP_PASS = 3'b100   // Second operand only
  } aluOp_t;

  typedef enum logic [`EXE_CVRULE_W-1:0] {
    CV_LOGIC = 2'd0,   // C from shifter, V kept
    CV_ADD   = 2'd1,
    CV_SUB   = 2'd2
  } cvRule_t;

  typedef struct packed {
    aluOp_t  op;
    logic    invertB;
    logic    reverseInputs;
    logic    carryIn;
    cvRule_t cvRule;
    logic    noWrite;        // Compare forms, flags only
  } aluCtrl_t;

endpackage

`default_nettype wire

/* verilog/armExe.sv */
`timescale 1ns/1ps
`default_nettype none

module armExe (
  input  logic               clk,
  input  logic               rst,
  input  exeIfPkg::exeReq_t  req,
  input  logic               inVld,
  output logic               inRdy,
  output exeIfPkg::exeResp_t resp,
  output logic               outVld,
  input  logic               outRdy
);

  // Single execute stage, one op per cycle
  exeStage exeStage_i (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .inVld  (inVld),
    .inRdy  (inRdy),
    .resp   (resp),
    .outVld (outVld),
    .outRdy (outRdy)
  );

endmodule

`default_nettype wire

/* verilog/armExe_settings.svh */
`ifndef ARMEXE_SETTINGS_SVH
`define ARMEXE_SETTINGS_SVH

// Datapath word, one ARM register
`define EXE_DATA_W 32

// Data-processing opcode, instruction bits 24..21
`define EXE_OPC_W 4

// Register number, r0..r15
`define EXE_REG_W 4

// Operation class select into the result mux
`define EXE_ALUOP_W 3

// Carry/overflow update rule select
`define EXE_CVRULE_W 2

`endif

/* verilog/exeIfPkg.sv */
`default_nettype none

`include "armExe_settings.svh"

package exeIfPkg;

  typedef logic [`EXE_REG_W-1:0] regNum_t;  // Destination register number

  // Condition flags, NZCV order
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    aluTypesPkg::opcode_t opcode;
    logic                 setFlags;  // S bit
    regNum_t              rd;
    aluTypesPkg::word_t   a;
    aluTypesPkg::word_t   b;         // Already shifted
    logic                 shCarry;   // Shifter carry-out
  } exeReq_t;

  typedef struct packed {
    aluTypesPkg::word_t result;
    regNum_t            rd;
    logic               wrEn;      // Low for TST TEQ CMP CMN
    flags_t             flags;     // Flag register after the op
  } exeResp_t;

endpackage

`default_nettype wire

/* verilog/exeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module exeStage (
  input  logic               clk,
  input  logic               rst,      // Sync, active high
  input  exeIfPkg::exeReq_t  req,
  input  logic               inVld,
  output logic               inRdy,
  output exeIfPkg::exeResp_t resp,
  output logic               outVld,
  input  logic               outRdy
);
  import aluTypesPkg::*;
  import exeIfPkg::*;

  aluCtrl_t ctrl;        // Decoded controls for the incoming request
  word_t    aluResult;
  flags_t   flagsQ;      // Architectural NZCV
  flags_t   flagsAlu;    // NZCV computed by this op
  flags_t   flagsNext;   // NZCV after this op, S bit applied
  logic     accept;

  // Stage is free when empty or draining this cycle
  assign inRdy  = ~outVld | outRdy;
  assign accept = inVld & inRdy;

  aluDecoder aluDecoder_i (
    .opcode    (req.opcode),
    .carryFlag (flagsQ.c),
    .ctrl      (ctrl)
  );

  aluDatapath aluDatapath_i (
    .ctrl     (ctrl),
    .a        (req.a),
    .b        (req.b),
    .shCarry  (req.shCarry),
    .flagsIn  (flagsQ),
    .result   (aluResult),
    .flagsOut (flagsAlu)
  );

  assign flagsNext = req.setFlags ? flagsAlu : flagsQ;

  // Valid bit and flag register
  always_ff @(posedge clk) begin
    if (rst) begin
      outVld <= 1'b0;
      flagsQ <= '0;
    end else begin
      if (accept) begin
        outVld <= 1'b1;
      end else if (outRdy) begin
        outVld <= 1'b0;       // Consumed, nothing new behind it
      end
      if (accept && req.setFlags) begin
        flagsQ <= flagsAlu;   // Next request sees it at once
      end
    end
  end

  // Response payload, held while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      resp.result <= aluResult;
      resp.rd     <= req.rd;
      resp.wrEn   <= ~ctrl.noWrite;   // Compares write flags only
      resp.flags  <= flagsNext;
    end
  end

endmodule

`default_nettype wire
